//--- source/tlu_config.svh
`ifndef TLU_CONFIG_SVH
`define TLU_CONFIG_SVH

// full TLU_CLOCK period in BUS_CLK cycles, even and at least 12
`define TLU_CLK_DIVISOR 12

// event FIFO holds 2**depth_log2 words
`define TLU_FIFO_DEPTH_LOG2 4

// near-full once free entries drop to this
`define TLU_FIFO_MARGIN 2

`endif

//--- source/tlu_pkg.sv
package tlu_pkg;

    // operating modes as written to register 1 bits 1:0
    typedef enum logic [1:0] {
        TLU_MODE_OFF          = 2'b00,
        TLU_MODE_NO_HANDSHAKE = 2'b01,
        TLU_MODE_SIMPLE       = 2'b10,
        TLU_MODE_DATA         = 2'b11
    } tlu_mode_t;

    // marker set, number received from the TLU
    typedef struct packed {
        logic        marker;
        logic [30:0] number;
    } tlu_number_word_t;

    // marker clear, internal trigger count
    typedef struct packed {
        logic        marker;
        logic [30:0] value;
    } tlu_count_word_t;

    // one 32-bit event word, decoded by its top bit
    typedef union packed {
        tlu_number_word_t tlu;
        tlu_count_word_t  count;
    } tlu_event_t;

endpackage

//--- source/tlu_register_file.sv
module tlu_register_file
    import tlu_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_wr,
    input  logic        bus_rd,
    input  logic [31:0] tlu_number,
    input  logic [31:0] trigger_count,
    output logic [7:0]  bus_data_out,
    output logic        soft_rst,
    output tlu_mode_t   tlu_mode,
    output logic        msb_first,
    output logic        disable_veto,
    output logic [4:0]  clock_cycles,
    output logic        enable_reset,
    output logic [7:0]  low_timeout
);

    logic [7:0]  mode_reg;
    logic [7:0]  cycles_reg;
    logic [7:0]  timeout_reg;
    logic [31:0] tlu_number_buf;
    logic [31:0] trigger_count_buf;
    logic        rd_tlu_low;
    logic        rd_count_low;

    // any write to address 0
    assign soft_rst = bus_wr && (bus_add == 16'd0);

    assign tlu_mode     = tlu_mode_t'(mode_reg[1:0]);
    assign msb_first    = mode_reg[2];
    assign disable_veto = mode_reg[3];
    assign clock_cycles = cycles_reg[4:0];
    assign enable_reset = cycles_reg[5];
    assign low_timeout  = timeout_reg;

    // reading the low byte freezes the whole 32-bit value
    assign rd_tlu_low   = bus_rd && (bus_add == 16'd4);
    assign rd_count_low = bus_rd && (bus_add == 16'd8);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            mode_reg    <= 8'h00;
            cycles_reg  <= 8'h00;
            timeout_reg <= 8'h00;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                16'd1:   mode_reg    <= bus_data_in;
                16'd2:   cycles_reg  <= bus_data_in;
                16'd3:   timeout_reg <= bus_data_in;
                default: ;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            tlu_number_buf    <= 32'd0;
            trigger_count_buf <= 32'd0;
        end
        else
        begin
            if (rd_tlu_low)
                tlu_number_buf <= tlu_number;
            if (rd_count_low)
                trigger_count_buf <= trigger_count;
        end
    end

    // low bytes come from the live value, loaded into the buffer on the same edge
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            bus_data_out <= 8'h00;
        else if (bus_rd)
        begin
            case (bus_add)
                16'd1:   bus_data_out <= mode_reg;
                16'd2:   bus_data_out <= cycles_reg;
                16'd3:   bus_data_out <= timeout_reg;
                16'd4:   bus_data_out <= tlu_number[7:0];
                16'd5:   bus_data_out <= tlu_number_buf[15:8];
                16'd6:   bus_data_out <= tlu_number_buf[23:16];
                16'd7:   bus_data_out <= tlu_number_buf[31:24];
                16'd8:   bus_data_out <= trigger_count[7:0];
                16'd9:   bus_data_out <= trigger_count_buf[15:8];
                16'd10:  bus_data_out <= trigger_count_buf[23:16];
                16'd11:  bus_data_out <= trigger_count_buf[31:24];
                default: bus_data_out <= 8'h00;
            endcase
        end
    end

endmodule

//--- source/tlu_trigger_input.sv
module tlu_trigger_input (
    input  logic BUS_CLK,
    input  logic RST,
    input  logic rj45_trigger,
    input  logic lemo_trigger,
    input  logic rj45_reset,
    input  logic lemo_reset,
    input  logic ext_veto,
    output logic rj45_enabled,
    output logic trigger_level,
    output logic trigger_rise,
    output logic reset_rise,
    output logic ext_veto_sync
);

    localparam int IDX_RJ45_TRG = 0;
    localparam int IDX_LEMO_TRG = 1;
    localparam int IDX_RJ45_RST = 2;
    localparam int IDX_LEMO_RST = 3;
    localparam int IDX_VETO     = 4;

    logic [4:0] sync_0;
    logic [4:0] sync_1;
    logic [4:0] sync_2;
    logic       sel_trigger;
    logic       sel_reset;
    logic       reset_level;
    logic       port_q;
    logic       port_stable;

    // three flops per line, all five lines in parallel
    always_ff @(posedge BUS_CLK)
    begin
        sync_0 <= {ext_veto, lemo_reset, rj45_reset, lemo_trigger, rj45_trigger};
        sync_1 <= sync_0;
        sync_2 <= sync_1;
    end

    assign ext_veto_sync = sync_2[IDX_VETO];

    // RJ45 lines idle high when unplugged, a low level means a cable is in
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            rj45_enabled <= 1'b0;
        else if (!sync_2[IDX_RJ45_TRG] || !sync_2[IDX_RJ45_RST])
            rj45_enabled <= 1'b1;
    end

    assign sel_trigger = rj45_enabled ? sync_2[IDX_RJ45_TRG] : sync_2[IDX_LEMO_TRG];
    assign sel_reset   = rj45_enabled ? sync_2[IDX_RJ45_RST] : sync_2[IDX_LEMO_RST];

    // no edge on the cycle the port switches over
    assign port_stable = (port_q == rj45_enabled);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            port_q        <= 1'b0;
            trigger_level <= 1'b0;
            reset_level   <= 1'b0;
            trigger_rise  <= 1'b0;
            reset_rise    <= 1'b0;
        end
        else
        begin
            port_q        <= rj45_enabled;
            trigger_level <= sel_trigger;
            reset_level   <= sel_reset;
            trigger_rise  <= sel_trigger && !trigger_level && port_stable;
            reset_rise    <= sel_reset && !reset_level && port_stable;
        end
    end

endmodule

//--- source/tlu_handshake_fsm.sv
`include "tlu_config.svh"

module tlu_handshake_fsm
    import tlu_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  tlu_mode_t   tlu_mode,
    input  logic        msb_first,
    input  logic        disable_veto,
    input  logic [4:0]  clock_cycles,
    input  logic        enable_reset,
    input  logic [7:0]  low_timeout,
    input  logic        trigger_level,
    input  logic        trigger_rise,
    input  logic        reset_rise,
    input  logic        ext_veto_sync,
    input  logic        fifo_full,
    input  logic        fifo_near_full,
    output logic        tlu_busy,
    output logic        tlu_clock,
    output logic        fifo_push,
    output tlu_event_t  event_word,
    output logic [31:0] tlu_number,
    output logic [31:0] trigger_count
);

    localparam int HALF_PERIOD = `TLU_CLK_DIVISOR / 2;
    localparam int DIV_W       = $clog2(`TLU_CLK_DIVISOR);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_WAIT_LOW = 2'd1;
    localparam logic [1:0] ST_CLOCKING = 2'd2;
    localparam logic [1:0] ST_PUSH     = 2'd3;

    logic [1:0]       state;
    logic [DIV_W-1:0] div_cnt;
    logic [7:0]       period_cnt;
    logic [4:0]       bit_cnt;
    logic [4:0]       n_bits;
    logic [4:0]       bit_idx;
    logic             veto;
    logic             veto_out;
    logic             accept;
    logic             half_done;
    logic             period_done;

    assign veto     = (ext_veto_sync || fifo_near_full) && !disable_veto;
    assign veto_out = veto && (tlu_mode != TLU_MODE_OFF);
    assign accept   = trigger_rise && !veto && (tlu_mode != TLU_MODE_OFF);

    // N of 0 stands for 31 bits
    assign n_bits  = (clock_cycles == 5'd0) ? 5'd31 : clock_cycles;
    assign bit_idx = msb_first ? (n_bits - 5'd1 - bit_cnt) : bit_cnt;

    assign half_done   = (div_cnt == DIV_W'(HALF_PERIOD - 1));
    assign period_done = (div_cnt == DIV_W'(`TLU_CLK_DIVISOR - 1));

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state         <= ST_IDLE;
            div_cnt       <= '0;
            period_cnt    <= 8'd0;
            bit_cnt       <= 5'd0;
            tlu_busy      <= 1'b0;
            tlu_clock     <= 1'b0;
            fifo_push     <= 1'b0;
            event_word    <= '0;
            tlu_number    <= 32'd0;
            trigger_count <= 32'd0;
        end
        else
        begin
            fifo_push <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    // veto holds busy and the TLU clock high
                    tlu_busy   <= veto_out;
                    tlu_clock  <= veto_out;
                    div_cnt    <= '0;
                    period_cnt <= 8'd0;
                    bit_cnt    <= 5'd0;
                    if (accept)
                    begin
                        trigger_count            <= trigger_count + 32'd1;
                        event_word.count.marker  <= 1'b0;
                        event_word.count.value   <= trigger_count[30:0];
                        if (tlu_mode == TLU_MODE_NO_HANDSHAKE)
                            state <= ST_PUSH;
                        else
                        begin
                            tlu_busy  <= 1'b1;
                            tlu_clock <= 1'b0;
                            state     <= ST_WAIT_LOW;
                        end
                    end
                end
                ST_WAIT_LOW:
                begin
                    // count whole TLU clock periods for the low timeout
                    if (period_done)
                    begin
                        div_cnt    <= '0;
                        period_cnt <= period_cnt + 8'd1;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;

                    if (!trigger_level)
                    begin
                        div_cnt <= '0;
                        if (tlu_mode == TLU_MODE_DATA)
                        begin
                            event_word.tlu.marker <= 1'b1;
                            event_word.tlu.number <= '0;
                            state                 <= ST_CLOCKING;
                        end
                        else
                            state <= ST_PUSH;
                    end
                    else if (low_timeout != 8'd0 && period_cnt == low_timeout)
                    begin
                        // abort, nothing pushed
                        tlu_busy <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                ST_CLOCKING:
                begin
                    if (half_done)
                    begin
                        div_cnt   <= '0;
                        tlu_clock <= !tlu_clock;
                        // sample on the falling TLU clock
                        if (tlu_clock)
                        begin
                            event_word.tlu.number[bit_idx] <= trigger_level;
                            bit_cnt                        <= bit_cnt + 5'd1;
                            if (bit_cnt == n_bits - 5'd1)
                                state <= ST_PUSH;
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                ST_PUSH:
                begin
                    // busy stays up while the FIFO is full
                    if (!fifo_full)
                    begin
                        fifo_push <= 1'b1;
                        tlu_busy  <= 1'b0;
                        state     <= ST_IDLE;
                        if (event_word.tlu.marker)
                            tlu_number <= {1'b0, event_word.tlu.number};
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase

            // external reset pulse wins over the increment
            if (reset_rise && enable_reset)
                trigger_count <= 32'd0;
        end
    end

endmodule

//--- source/tlu_event_fifo.sv
`include "tlu_config.svh"

module tlu_event_fifo
    import tlu_pkg::*;
(
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       push,
    input  tlu_event_t push_word,
    input  logic       fifo_read,
    output tlu_event_t fifo_data,
    output logic       fifo_empty,
    output logic       fifo_full,
    output logic       fifo_near_full
);

    localparam int AW    = `TLU_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    localparam logic [AW:0] FULL_LEVEL = (AW + 1)'(DEPTH);
    localparam logic [AW:0] NEAR_LEVEL = (AW + 1)'(DEPTH - `TLU_FIFO_MARGIN);

    tlu_event_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !fifo_full;
    assign do_pop  = fifo_read && !fifo_empty;

    assign fifo_empty     = (level == '0);
    assign fifo_full      = (level == FULL_LEVEL);
    assign fifo_near_full = (level >= NEAR_LEVEL);

    // head word shows without a read
    assign fifo_data = mem[rd_ptr];

    always_ff @(posedge BUS_CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
        end
    end

endmodule

//--- source/tlu_controller.sv
module tlu_controller
    import tlu_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] BUS_ADD,
    input  logic [7:0]  BUS_DATA_IN,
    input  logic        BUS_WR,
    input  logic        BUS_RD,
    output logic [7:0]  BUS_DATA_OUT,
    input  logic        RJ45_TRIGGER,
    input  logic        LEMO_TRIGGER,
    input  logic        RJ45_RESET,
    input  logic        LEMO_RESET,
    input  logic        EXT_VETO,
    output logic        RJ45_ENABLED,
    output logic        TLU_BUSY,
    output logic        TLU_CLOCK,
    input  logic        FIFO_READ,
    output logic        FIFO_EMPTY,
    output logic [31:0] FIFO_DATA
);

    logic        soft_rst;
    logic        rst_int;
    tlu_mode_t   tlu_mode;
    logic        msb_first;
    logic        disable_veto;
    logic [4:0]  clock_cycles;
    logic        enable_reset;
    logic [7:0]  low_timeout;
    logic        trigger_level;
    logic        trigger_rise;
    logic        reset_rise;
    logic        ext_veto_sync;
    logic        fifo_push;
    logic        fifo_full;
    logic        fifo_near_full;
    tlu_event_t  event_word;
    logic [31:0] tlu_number;
    logic [31:0] trigger_count;

    // bus write to address 0 resets everything for one cycle
    assign rst_int = RST || soft_rst;

    tlu_register_file u_register_file (
        .BUS_CLK       (BUS_CLK),
        .RST           (rst_int),
        .bus_add       (BUS_ADD),
        .bus_data_in   (BUS_DATA_IN),
        .bus_wr        (BUS_WR),
        .bus_rd        (BUS_RD),
        .tlu_number    (tlu_number),
        .trigger_count (trigger_count),
        .bus_data_out  (BUS_DATA_OUT),
        .soft_rst      (soft_rst),
        .tlu_mode      (tlu_mode),
        .msb_first     (msb_first),
        .disable_veto  (disable_veto),
        .clock_cycles  (clock_cycles),
        .enable_reset  (enable_reset),
        .low_timeout   (low_timeout)
    );

    tlu_trigger_input u_trigger_input (
        .BUS_CLK       (BUS_CLK),
        .RST           (rst_int),
        .rj45_trigger  (RJ45_TRIGGER),
        .lemo_trigger  (LEMO_TRIGGER),
        .rj45_reset    (RJ45_RESET),
        .lemo_reset    (LEMO_RESET),
        .ext_veto      (EXT_VETO),
        .rj45_enabled  (RJ45_ENABLED),
        .trigger_level (trigger_level),
        .trigger_rise  (trigger_rise),
        .reset_rise    (reset_rise),
        .ext_veto_sync (ext_veto_sync)
    );

    tlu_handshake_fsm u_handshake_fsm (
        .BUS_CLK        (BUS_CLK),
        .RST            (rst_int),
        .tlu_mode       (tlu_mode),
        .msb_first      (msb_first),
        .disable_veto   (disable_veto),
        .clock_cycles   (clock_cycles),
        .enable_reset   (enable_reset),
        .low_timeout    (low_timeout),
        .trigger_level  (trigger_level),
        .trigger_rise   (trigger_rise),
        .reset_rise     (reset_rise),
        .ext_veto_sync  (ext_veto_sync),
        .fifo_full      (fifo_full),
        .fifo_near_full (fifo_near_full),
        .tlu_busy       (TLU_BUSY),
        .tlu_clock      (TLU_CLOCK),
        .fifo_push      (fifo_push),
        .event_word     (event_word),
        .tlu_number     (tlu_number),
        .trigger_count  (trigger_count)
    );

    tlu_event_fifo u_event_fifo (
        .BUS_CLK        (BUS_CLK),
        .RST            (rst_int),
        .push           (fifo_push),
        .push_word      (event_word),
        .fifo_read      (FIFO_READ),
        .fifo_data      (FIFO_DATA),
        .fifo_empty     (FIFO_EMPTY),
        .fifo_full      (fifo_full),
        .fifo_near_full (fifo_near_full)
    );

endmodule

//--- dv/tlu_tb_tasks.svh
`ifndef TLU_TB_TASKS_SVH
`define TLU_TB_TASKS_SVH

// drive point, just after the next rising edge
task automatic step();
    @(posedge BUS_CLK);
    #2;
endtask

task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    bus_add     = addr;
    bus_data_in = data;
    bus_wr      = 1'b1;
    step();
    bus_wr = 1'b0;
endtask

// read data is registered on the strobe edge
task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
    bus_add = addr;
    bus_rd  = 1'b1;
    step();
    bus_rd = 1'b0;
    data   = bus_data_out;
endtask

task automatic check_byte(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
    if (actual !== expected)
    begin
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end_with_failure();
    end
endtask

task automatic check_event(input string name, input tlu_event_t expected,
                           input tlu_event_t actual);
    if (actual !== expected)
    begin
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end_with_failure();
    end
endtask

// low byte first, that read freezes the other three
task automatic check_snapshot(input logic [15:0] base, input logic [31:0] expected,
                              input string name);
    logic [7:0] data;
    for (int i = 0; i < 4; i++)
    begin
        bus_read(base + 16'(i), data);
        check_byte($sformatf("%s byte %0d", name, i), expected[8*i +: 8], data);
    end
endtask

function automatic logic output_level(input int sel);
    case (sel)
        SEL_BUSY:  return tlu_busy;
        SEL_EMPTY: return fifo_empty;
        default:   return rj45_enabled;
    endcase
endfunction

task automatic wait_level(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    while (output_level(sel) !== level)
    begin
        if (cycles >= WAIT_LIMIT)
            abort_run($sformatf("timeout waiting for %s", what));
        step();
        cycles++;
    end
endtask

function automatic tlu_event_t count_word(input int n);
    tlu_event_t word;
    word.count.marker = 1'b0;
    word.count.value  = 31'(n);
    return word;
endfunction

function automatic tlu_event_t number_word(input logic [30:0] number);
    tlu_event_t word;
    word.tlu.marker = 1'b1;
    word.tlu.number = number;
    return word;
endfunction

// head word is valid while not empty, one read strobe pops it
task automatic expect_word(input tlu_event_t expected);
    tlu_event_t got;
    wait_level(SEL_EMPTY, 1'b0, "FIFO_EMPTY to go low");
    got = fifo_data;
    check_event("FIFO_DATA", expected, got);
    fifo_read = 1'b1;
    step();
    fifo_read = 1'b0;
endtask

task automatic pulse_trigger(input logic on_rj45);
    if (on_rj45)
        rj45_trigger = 1'b1;
    else
        lemo_drive = 1'b1;
    repeat (3) step();
    if (on_rj45)
        rj45_trigger = 1'b0;
    else
        lemo_drive = 1'b0;
    repeat (6) step();
endtask

task automatic pulse_reset();
    lemo_reset = 1'b1;
    repeat (3) step();
    lemo_reset = 1'b0;
    repeat (6) step();
endtask

// request, acknowledge, release, optional number shift, busy drops
task automatic tlu_handshake(input logic with_data, input logic [30:0] number,
                             input int bits, input logic msb);
    if (tlu_busy !== 1'b0)
        abort_run("TLU_BUSY high before the trigger request");
    lemo_drive = 1'b1;
    wait_level(SEL_BUSY, 1'b1, "TLU_BUSY to acknowledge the trigger");
    if (with_data)
    begin
        model_number = number;
        model_bits   = bits;
        model_msb    = msb;
        model_idx    = 0;
        model_line   = 1'b0;
        model_active = 1'b1;
    end
    lemo_drive = 1'b0;
    wait_level(SEL_BUSY, 1'b0, "TLU_BUSY to release");
    if (with_data && model_idx != bits)
        abort_run("TLU_BUSY fell before all TLU_CLOCK periods were sent");
    if (tlu_clock !== 1'b0)
        abort_run("TLU_CLOCK left high after the handshake");
    model_active = 1'b0;
endtask

`endif

//--- dv/tlu_tb.sv
`include "tlu_config.svh"

module tlu_tb
    import tlu_pkg::*;
();

    localparam int WAIT_LIMIT = 1000;
    localparam int DEPTH      = 1 << `TLU_FIFO_DEPTH_LOG2;
    localparam int SEL_BUSY   = 0;
    localparam int SEL_EMPTY  = 1;
    localparam int SEL_RJ45   = 2;

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_out;
    logic        rj45_trigger;
    logic        lemo_trigger;
    logic        rj45_reset;
    logic        lemo_reset;
    logic        ext_veto;
    logic        rj45_enabled;
    logic        tlu_busy;
    logic        tlu_clock;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;

    logic        lemo_drive;
    logic        model_active;
    logic        model_line;
    logic        model_msb;
    logic [30:0] model_number;
    int          model_bits;
    int          model_idx;
    logic        clock_q;
    integer      seed;

    // the TLU model owns the LEMO trigger line while it shifts a number out
    assign lemo_trigger = model_active ? model_line : lemo_drive;

    initial
    begin
        BUS_CLK = 1'b0;
        forever #20 BUS_CLK = ~BUS_CLK;
    end

    tlu_controller u_tlu_controller (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .BUS_ADD      (bus_add),
        .BUS_DATA_IN  (bus_data_in),
        .BUS_WR       (bus_wr),
        .BUS_RD       (bus_rd),
        .BUS_DATA_OUT (bus_data_out),
        .RJ45_TRIGGER (rj45_trigger),
        .LEMO_TRIGGER (lemo_trigger),
        .RJ45_RESET   (rj45_reset),
        .LEMO_RESET   (lemo_reset),
        .EXT_VETO     (ext_veto),
        .RJ45_ENABLED (rj45_enabled),
        .TLU_BUSY     (tlu_busy),
        .TLU_CLOCK    (tlu_clock),
        .FIFO_READ    (fifo_read),
        .FIFO_EMPTY   (fifo_empty),
        .FIFO_DATA    (fifo_data)
    );

    // next bit goes out after each rising TLU_CLOCK
    always @(posedge BUS_CLK)
    begin
        #2;
        if (model_active && tlu_clock && !clock_q && model_idx < model_bits)
        begin
            if (model_msb)
                model_line = model_number[model_bits - 1 - model_idx];
            else
                model_line = model_number[model_idx];
            model_idx = model_idx + 1;
        end
        clock_q = tlu_clock;
    end

    `include "tlu_tb_tasks.svh"

    task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        end_with_failure();
    endtask

    task automatic register_access();
        logic [7:0] values [3];
        logic [7:0] data;
        values = '{8'h0d, 8'h35, 8'hc4};
        for (int i = 0; i < 3; i++)
            bus_write(16'(i + 1), values[i]);
        for (int i = 0; i < 3; i++)
        begin
            bus_read(16'(i + 1), data);
            check_byte($sformatf("register %0d", i + 1), values[i], data);
        end
        bus_read(16'd12, data);
        check_byte("register 12", 8'h00, data);
        // soft reset clears the configuration
        bus_write(16'd0, 8'h00);
        for (int i = 0; i < 3; i++)
        begin
            bus_read(16'(i + 1), data);
            check_byte($sformatf("register %0d after soft reset", i + 1), 8'h00, data);
        end
    endtask

    task automatic no_handshake_counts();
        bus_write(16'd0, 8'h00);
        bus_write(16'd1, 8'h01);
        repeat (3) pulse_trigger(1'b0);
        for (int i = 0; i < 3; i++)
            expect_word(count_word(i));
        check_snapshot(16'd8, 32'd3, "trigger count snapshot");
    endtask

    task automatic data_mode_numbers();
        logic [14:0] number;
        logic        msb;
        bus_write(16'd0, 8'h00);
        bus_write(16'd2, 8'd15);
        for (int pass = 0; pass < 2; pass++)
        begin
            msb    = (pass == 1);
            number = 15'($random(seed));
            bus_write(16'd1, {5'b00000, msb, 2'b11});
            tlu_handshake(1'b1, 31'(number), 15, msb);
            expect_word(number_word(31'(number)));
            check_snapshot(16'd4, 32'(number), "TLU number snapshot");
        end
    endtask

    task automatic simple_handshake_timeout();
        bus_write(16'd0, 8'h00);
        bus_write(16'd1, 8'h02);
        tlu_handshake(1'b0, 31'd0, 0, 1'b0);
        expect_word(count_word(0));
        // hold the request past one TLU_CLOCK period
        bus_write(16'd3, 8'h01);
        lemo_drive = 1'b1;
        wait_level(SEL_BUSY, 1'b1, "TLU_BUSY on the held trigger");
        wait_level(SEL_BUSY, 1'b0, "TLU_BUSY to drop after the low timeout");
        lemo_drive = 1'b0;
        repeat (6) step();
        if (fifo_empty !== 1'b1)
            abort_run("aborted handshake pushed an event word");
        // the aborted trigger was still counted
        tlu_handshake(1'b0, 31'd0, 0, 1'b0);
        expect_word(count_word(2));
    endtask

    task automatic veto_reset_and_rj45();
        bus_write(16'd0, 8'h00);
        bus_write(16'd1, 8'h02);
        bus_write(16'd2, 8'h20);
        ext_veto = 1'b1;
        wait_level(SEL_BUSY, 1'b1, "TLU_BUSY under the external veto");
        pulse_trigger(1'b0);
        if (tlu_busy !== 1'b1 || tlu_clock !== 1'b1 || fifo_empty !== 1'b1)
            abort_run("trigger handled while the veto was active");
        ext_veto = 1'b0;
        wait_level(SEL_BUSY, 1'b0, "TLU_BUSY after the veto release");
        tlu_handshake(1'b0, 31'd0, 0, 1'b0);
        expect_word(count_word(0));
        tlu_handshake(1'b0, 31'd0, 0, 1'b0);
        expect_word(count_word(1));
        pulse_reset();
        check_snapshot(16'd8, 32'd0, "trigger count after reset pulse");
        tlu_handshake(1'b0, 31'd0, 0, 1'b0);
        expect_word(count_word(0));
        // plugging in RJ45 moves triggers to that port
        bus_write(16'd1, 8'h01);
        rj45_trigger = 1'b0;
        wait_level(SEL_RJ45, 1'b1, "RJ45_ENABLED");
        pulse_trigger(1'b1);
        expect_word(count_word(1));
        bus_write(16'd1, 8'h00);
        rj45_trigger = 1'b1;
        repeat (6) step();
    endtask

    task automatic fifo_fill_and_drain();
        int count;
        bus_write(16'd0, 8'h00);
        bus_write(16'd1, 8'h01);
        repeat (20) pulse_trigger(1'b0);
        if (tlu_busy !== 1'b1)
            abort_run("near-full FIFO did not raise the veto");
        count = 0;
        while (fifo_empty !== 1'b1)
        begin
            if (count >= 2 * DEPTH)
                abort_run("FIFO did not drain");
            expect_word(count_word(count));
            count++;
        end
        check_byte("drained word count", 8'(DEPTH - `TLU_FIFO_MARGIN), 8'(count));
        wait_level(SEL_BUSY, 1'b0, "TLU_BUSY after the FIFO drained");
    endtask

    initial
    begin
        seed         = 32'h80b4;
        RST          = 1'b1;
        bus_add      = 16'h0000;
        bus_data_in  = 8'h00;
        bus_wr       = 1'b0;
        bus_rd       = 1'b0;
        rj45_trigger = 1'b1;
        rj45_reset   = 1'b1;
        lemo_drive   = 1'b0;
        lemo_reset   = 1'b0;
        ext_veto     = 1'b0;
        fifo_read    = 1'b0;
        model_active = 1'b0;
        model_line   = 1'b0;
        model_msb    = 1'b0;
        model_number = 31'd0;
        model_bits   = 0;
        model_idx    = 0;
        clock_q      = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        #2;
        if (tlu_busy !== 1'b0 || tlu_clock !== 1'b0 || rj45_enabled !== 1'b0
            || fifo_empty !== 1'b1)
            abort_run("outputs not in their reset state");
        RST = 1'b0;
        register_access();
        no_handshake_counts();
        data_mode_numbers();
        simple_handshake_timeout();
        veto_reset_and_rj45();
        fifo_fill_and_drain();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- files.f
+incdir+source
+incdir+dv
source/tlu_pkg.sv
source/tlu_register_file.sv
source/tlu_trigger_input.sv
source/tlu_handshake_fsm.sv
source/tlu_event_fifo.sv
source/tlu_controller.sv
dv/tlu_tb.sv
